//--- mem_geom_pkg.sv
/*
 * Address geometry of the cache and the banked main memory:
 * field widths, word and tag-entry types, bank timing constants
 */
package mem_geom_pkg;

   localparam int tag_w = 5;
   localparam int index_w = 8;
   localparam int words_per_line = 4;
   localparam int word_w = 16;
   localparam int woff_w = $clog2(words_per_line);

   localparam int num_lines = 1 << index_w;
   localparam int bank_depth = 1 << (tag_w + index_w);

   localparam int mem_latency = 2;
   localparam int bank_busy_cycles = 4;

   typedef logic [word_w-1:0]  word_t;
   typedef logic [tag_w-1:0]   tag_t;
   typedef logic [index_w-1:0] index_t;
   typedef logic [woff_w-1:0]  woff_t;
   typedef logic [$clog2(bank_busy_cycles + 1)-1:0] bank_timer_t;

   // Word offset doubles as the bank number
   localparam woff_t last_woff = woff_t'(words_per_line - 1);

   typedef struct packed {
      tag_t   tag;
      index_t index;
      woff_t  woff;
      logic   byte_sel;
   } addr_t;

   typedef struct packed {
      logic valid;
      logic dirty;
      tag_t tag;
   } tag_entry_t;

endpackage

//--- mem_req_pkg.sv
/*
 * Transaction structs: processor request and response,
 * cache array command and status, single bank access and return
 */
package mem_req_pkg;

   typedef struct packed {
      logic                rd;
      logic                wr;
      mem_geom_pkg::addr_t addr;
      mem_geom_pkg::word_t data;
   } mem_req_t;

   typedef struct packed {
      mem_geom_pkg::word_t data;
      logic                done;
      logic                stall;
      logic                hit;
   } mem_resp_t;

   // comp high: word from the request; low: fill or writeback word
   typedef struct packed {
      logic                enable;
      logic                comp;
      logic                write;
      logic                dirty_in;
      mem_geom_pkg::woff_t woff;
   } cache_cmd_t;

   typedef struct packed {
      logic                 rd;
      logic                 wr;
      mem_geom_pkg::tag_t   tag;
      mem_geom_pkg::index_t index;
      mem_geom_pkg::woff_t  woff;
      mem_geom_pkg::word_t  data;
   } bank_req_t;

   typedef struct packed {
      logic                valid;
      mem_geom_pkg::woff_t woff;
      mem_geom_pkg::word_t data;
   } bank_resp_t;

   typedef struct packed {
      logic               hit;
      logic               dirty;
      logic               valid;
      mem_geom_pkg::tag_t tag;
   } cache_status_t;

endpackage

//--- line_ram.sv
/*
 * Generic storage array, synchronous write, combinational read
 */
module line_ram #(
   parameter type T = logic [15:0],
   parameter int depth = 256
) (
   input  logic                     clk,
   input  logic                     we,
   input  logic [$clog2(depth)-1:0] waddr,
   input  T                         wdata,
   input  logic [$clog2(depth)-1:0] raddr,
   output T                         rdata
);

   T mem [depth];

   // Contents power up as zero
   initial begin
      for (int i = 0; i < depth; i++) begin
         mem[i] = '0;
      end
   end

   always @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   assign rdata = mem[raddr];

endmodule

//--- cache_array.sv
/*
 * Direct-mapped cache storage: tag entries, valid bits, data words,
 * tag compare with hit and dirty status
 */
module cache_array (
   input  logic                       clk,
   input  logic                       rst_n,
   input  mem_req_pkg::cache_cmd_t    cmd,
   input  mem_geom_pkg::addr_t        addr,
   input  mem_geom_pkg::word_t        wdata,
   output mem_geom_pkg::word_t        rdata,
   output mem_req_pkg::cache_status_t status
);

   logic [mem_geom_pkg::num_lines-1:0] valid_q;
   mem_geom_pkg::tag_entry_t entry_rd;
   mem_geom_pkg::tag_entry_t entry_wr;
   logic line_valid;
   logic tag_match;
   logic cmp_write;
   logic fill_write;
   logic fill_last;
   logic data_we;
   logic tag_we;

   assign line_valid = valid_q[addr.index] & entry_rd.valid;
   assign tag_match = (entry_rd.tag == addr.tag);

   always_comb begin
      status.valid = line_valid;
      status.dirty = line_valid & entry_rd.dirty;
      status.tag = entry_rd.tag;
      status.hit = line_valid & tag_match;
   end

   assign cmp_write = cmd.enable & cmd.write & cmd.comp;
   assign fill_write = cmd.enable & cmd.write & ~cmd.comp;
   assign fill_last = fill_write & (cmd.woff == mem_geom_pkg::last_woff);

   assign data_we = fill_write | (cmp_write & status.hit);
   assign tag_we = fill_last | (cmp_write & status.hit);

   // Compare write marks dirty, last fill word installs a clean line
   assign entry_wr = '{valid: 1'b1, dirty: cmd.dirty_in, tag: addr.tag};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= '0;
      end else if (fill_last) begin
         valid_q[addr.index] <= 1'b1;
      end
   end

   line_ram #(
      .T     (mem_geom_pkg::tag_entry_t),
      .depth (mem_geom_pkg::num_lines)
   ) u_tag_ram (
      .clk   (clk),
      .we    (tag_we),
      .waddr (addr.index),
      .wdata (entry_wr),
      .raddr (addr.index),
      .rdata (entry_rd)
   );

   line_ram #(
      .T     (mem_geom_pkg::word_t),
      .depth (mem_geom_pkg::num_lines * mem_geom_pkg::words_per_line)
   ) u_data_ram (
      .clk   (clk),
      .we    (data_we),
      .waddr ({addr.index, cmd.woff}),
      .wdata (wdata),
      .raddr ({addr.index, cmd.woff}),
      .rdata (rdata)
   );

   // Controller only writes in compare mode after seeing a hit
   a_cmp_write_hit: assert property (@(posedge clk) disable iff (!rst_n)
      cmp_write |-> status.hit);

endmodule

//--- bank_mem.sv
/*
 * Four-bank interleaved main memory with per-bank busy timers
 * and a fixed-latency read return pipeline
 */
module bank_mem (
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  mem_req_pkg::bank_req_t                    req,
   output mem_req_pkg::bank_resp_t                   resp,
   output logic [mem_geom_pkg::words_per_line-1:0]   busy
);

   localparam int nbanks = mem_geom_pkg::words_per_line;
   localparam int lat = mem_geom_pkg::mem_latency;

   logic [mem_geom_pkg::tag_w+mem_geom_pkg::index_w-1:0] bank_addr;
   mem_geom_pkg::word_t rd_word [nbanks];
   logic access;

   logic [lat-1:0]      vld_q;
   mem_geom_pkg::woff_t woff_q [lat];
   mem_geom_pkg::word_t data_q [lat];

   assign bank_addr = {req.tag, req.index};
   assign access = req.rd | req.wr;

   for (genvar b = 0; b < nbanks; b++) begin : g_bank
      logic sel;
      mem_geom_pkg::bank_timer_t timer_q;

      assign sel = (req.woff == mem_geom_pkg::woff_t'(b));

      line_ram #(
         .T     (mem_geom_pkg::word_t),
         .depth (mem_geom_pkg::bank_depth)
      ) u_ram (
         .clk   (clk),
         .we    (sel & req.wr),
         .waddr (bank_addr),
         .wdata (req.data),
         .raddr (bank_addr),
         .rdata (rd_word[b])
      );

      // Busy countdown restarts on every access
      always_ff @(posedge clk) begin
         if (!rst_n) begin
            timer_q <= '0;
         end else if (sel && access) begin
            timer_q <= mem_geom_pkg::bank_timer_t'(mem_geom_pkg::bank_busy_cycles);
         end else if (timer_q != '0) begin
            timer_q <= timer_q - 1'b1;
         end
      end

      assign busy[b] = (timer_q != '0);
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld_q <= '0;
      end else begin
         vld_q[0] <= req.rd;
         for (int s = 1; s < lat; s++) begin
            vld_q[s] <= vld_q[s-1];
         end
      end
   end

   // Word is sampled at issue and then carried along
   always_ff @(posedge clk) begin
      woff_q[0] <= req.woff;
      data_q[0] <= rd_word[req.woff];
      for (int s = 1; s < lat; s++) begin
         woff_q[s] <= woff_q[s-1];
         data_q[s] <= data_q[s-1];
      end
   end

   assign resp = '{valid: vld_q[lat-1], woff: woff_q[lat-1], data: data_q[lat-1]};

   a_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
      access |-> !busy[req.woff]);

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(req.rd && req.wr));

endmodule

//--- cache_ctrl.sv
/*
 * Miss-handling FSM: compare, writeback, fill issue, fill wait, retry,
 * and the Done, Stall and CacheHit flags
 */
module cache_ctrl (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  mem_req_pkg::mem_req_t                   req,
   input  mem_req_pkg::cache_status_t              status,
   input  logic [mem_geom_pkg::words_per_line-1:0] bank_busy,
   input  mem_req_pkg::bank_resp_t                 bank_resp,
   output mem_req_pkg::cache_cmd_t                 cmd,
   output mem_req_pkg::bank_req_t                  bank_req,
   output logic                                    wb_phase,
   output logic                                    done,
   output logic                                    stall,
   output logic                                    hit
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_WB,
      S_FILL,
      S_FWAIT,
      S_RETRY
   } state_t;

   state_t state;
   state_t state_nx;
   mem_geom_pkg::woff_t cnt;
   mem_geom_pkg::woff_t rcnt;
   logic req_act;
   logic issue;
   logic fill_ret;

   function automatic mem_req_pkg::cache_cmd_t compare_cmd(input mem_req_pkg::mem_req_t r,
                                                           input logic lookup_hit);
      mem_req_pkg::cache_cmd_t c;
      c.enable = r.rd | r.wr;
      c.comp = 1'b1;
      c.write = r.wr & lookup_hit;
      c.dirty_in = 1'b1;
      c.woff = r.addr.woff;
      return c;
   endfunction

   assign req_act = req.rd | req.wr;
   assign fill_ret = bank_resp.valid & ((state == S_FILL) | (state == S_FWAIT));
   assign wb_phase = (state == S_WB);

   always_comb begin
      state_nx = state;
      issue = 1'b0;
      cmd = '0;
      // Address and write data are steered in the top
      bank_req = '0;
      done = 1'b0;
      stall = 1'b1;
      hit = 1'b0;

      case (state)
         S_IDLE: begin
            cmd = compare_cmd(req, status.hit);
            done = req_act & status.hit;
            stall = req_act & ~status.hit;
            hit = req_act & status.hit;
            if (req_act && !status.hit) begin
               state_nx = (status.valid && status.dirty) ? S_WB : S_FILL;
            end
         end
         S_WB: begin
            // Read victim word while writing it out
            cmd.enable = 1'b1;
            cmd.woff = cnt;
            bank_req.woff = cnt;
            if (!bank_busy[cnt]) begin
               issue = 1'b1;
               bank_req.wr = 1'b1;
            end
            if (issue && cnt == mem_geom_pkg::last_woff) begin
               state_nx = S_FILL;
            end
         end
         S_FILL: begin
            bank_req.woff = cnt;
            if (!bank_busy[cnt]) begin
               issue = 1'b1;
               bank_req.rd = 1'b1;
            end
            if (issue && cnt == mem_geom_pkg::last_woff) begin
               state_nx = S_FWAIT;
            end
         end
         S_FWAIT: begin
            if (fill_ret && rcnt == mem_geom_pkg::last_woff) begin
               state_nx = S_RETRY;
            end
         end
         S_RETRY: begin
            cmd = compare_cmd(req, status.hit);
            done = 1'b1;
            stall = 1'b0;
            state_nx = S_IDLE;
         end
         default: begin
            state_nx = S_IDLE;
         end
      endcase

      // Returned words go straight into the line
      if (fill_ret) begin
         cmd.enable = 1'b1;
         cmd.write = 1'b1;
         cmd.woff = bank_resp.woff;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= S_IDLE;
         cnt <= '0;
         rcnt <= '0;
      end else begin
         state <= state_nx;
         if (issue) begin
            cnt <= cnt + 1'b1;
         end
         if (fill_ret) begin
            rcnt <= rcnt + 1'b1;
         end
      end
   end

   // Completion only with the requested line resident
   a_done_stall: assert property (@(posedge clk) disable iff (!rst_n)
      done |-> (!stall && status.hit));

   // Fill words cannot come back before they were requested
   a_ret_le_issue: assert property (@(posedge clk) disable iff (!rst_n)
      (state == S_FILL) |-> (rcnt <= cnt));

endmodule

//--- mem_system.sv
/*
 * Memory subsystem top: request capture, cache/bank data steering,
 * cache array, bank memory and controller instances
 */
module mem_system (
   input  logic                   clk,
   input  logic                   rst_n,
   input  mem_req_pkg::mem_req_t  req,
   output mem_req_pkg::mem_resp_t resp
);

   mem_req_pkg::mem_req_t      req_q;
   mem_req_pkg::cache_cmd_t    cache_cmd;
   mem_req_pkg::cache_status_t status;
   mem_req_pkg::bank_req_t     ctrl_bank_req;
   mem_req_pkg::bank_req_t     bank_req;
   mem_req_pkg::bank_resp_t    bank_resp;
   logic [mem_geom_pkg::words_per_line-1:0] bank_busy;
   mem_geom_pkg::word_t cache_wdata;
   mem_geom_pkg::word_t cache_rdata;
   logic wb_phase;
   logic done;
   logic stall;
   logic hit;

   // Request held while stalled, strobes cleared by reset
   always_ff @(posedge clk) begin
      if (!stall) begin
         req_q <= req;
      end
      if (!rst_n) begin
         req_q.rd <= 1'b0;
         req_q.wr <= 1'b0;
      end
   end

   assign cache_wdata = cache_cmd.comp ? req_q.data : bank_resp.data;

   // Victim tag during writeback
   assign bank_req = '{rd:    ctrl_bank_req.rd,
                       wr:    ctrl_bank_req.wr,
                       tag:   wb_phase ? status.tag : req_q.addr.tag,
                       index: req_q.addr.index,
                       woff:  ctrl_bank_req.woff,
                       data:  cache_rdata};

   assign resp = '{data: cache_rdata, done: done, stall: stall, hit: hit};

   cache_array u_cache (
      .clk    (clk),
      .rst_n  (rst_n),
      .cmd    (cache_cmd),
      .addr   (req_q.addr),
      .wdata  (cache_wdata),
      .rdata  (cache_rdata),
      .status (status)
   );

   bank_mem u_mem (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (bank_req),
      .resp  (bank_resp),
      .busy  (bank_busy)
   );

   cache_ctrl u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req_q),
      .status    (status),
      .bank_busy (bank_busy),
      .bank_resp (bank_resp),
      .cmd       (cache_cmd),
      .bank_req  (ctrl_bank_req),
      .wb_phase  (wb_phase),
      .done      (done),
      .stall     (stall),
      .hit       (hit)
   );

endmodule

//--- mem_system_tb.sv
/*
 * Testbench for the memory subsystem: clock, reset, LFSR stimulus,
 * shadow memory and tag-table model, stimulus table and check tasks
 */
module mem_system_tb;

   localparam int wait_limit = 100;
   localparam int num_random = 40;

   typedef struct packed {
      logic                wr;
      mem_geom_pkg::addr_t addr;
      mem_geom_pkg::word_t data;
      mem_geom_pkg::word_t exp_data;
      logic                exp_hit;
   } row_t;

   logic clk;
   logic rst_n;
   mem_req_pkg::mem_req_t  req;
   mem_req_pkg::mem_resp_t resp;

   logic [15:0] lfsr;
   row_t rows[$];
   mem_geom_pkg::word_t model_mem [1 << 15];
   logic [mem_geom_pkg::num_lines-1:0] line_valid;
   mem_geom_pkg::tag_t line_tag [mem_geom_pkg::num_lines];

   mem_system uut (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req),
      .resp  (resp)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[14:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic stop_with_failure();
      $display("Something failed");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic check_word(input string name, input mem_geom_pkg::word_t got,
                             input mem_geom_pkg::word_t exp);
      if (got !== exp) begin
         $display("** Error: %s got %h expected %h", name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error: %s got %h expected %h", name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic add_row(input logic wr, input logic [15:0] addr,
                          input mem_geom_pkg::word_t data);
      row_t r;
      r = '0;
      r.wr = wr;
      r.addr = mem_geom_pkg::addr_t'(addr);
      r.data = data;
      rows.push_back(r);
   endtask

   // Write-allocate: every access leaves its tag resident in the line
   task automatic predict_rows();
      row_t r;
      int widx;
      for (int i = 0; i < rows.size(); i++) begin
         r = rows[i];
         widx = int'({r.addr.tag, r.addr.index, r.addr.woff});
         r.exp_hit = line_valid[r.addr.index] && (line_tag[r.addr.index] == r.addr.tag);
         if (r.wr) begin
            model_mem[widx] = r.data;
         end
         r.exp_data = model_mem[widx];
         line_valid[r.addr.index] = 1'b1;
         line_tag[r.addr.index] = r.addr.tag;
         rows[i] = r;
      end
   endtask

   task automatic apply_row(input row_t r, input int n);
      int cycles;
      cycles = 0;
      while (resp.stall) begin
         if (cycles >= wait_limit) begin
            $display("Timeout: Stall stayed high before row %0d", n);
            stop_with_failure();
         end
         @(negedge clk);
         cycles++;
      end
      req.rd = ~r.wr;
      req.wr = r.wr;
      req.addr = r.addr;
      req.data = r.data;
      @(negedge clk);
      req.rd = 1'b0;
      req.wr = 1'b0;
      cycles = 0;
      while (!resp.done) begin
         if (cycles >= wait_limit) begin
            $display("Timeout: no Done for row %0d", n);
            stop_with_failure();
         end
         @(negedge clk);
         cycles++;
      end
      check_flag($sformatf("resp.stall row %0d", n), resp.stall, 1'b0);
      check_flag($sformatf("resp.hit row %0d", n), resp.hit, r.exp_hit);
      if (!r.wr) begin
         check_word($sformatf("resp.data row %0d", n), resp.data, r.exp_data);
      end
      // Done is a single-cycle pulse
      @(negedge clk);
      check_flag($sformatf("resp.done after row %0d", n), resp.done, 1'b0);
   endtask

   initial begin
      mem_geom_pkg::addr_t a;
      logic op;
      mem_geom_pkg::word_t d;

      rst_n = 1'b0;
      req = '0;
      lfsr = 16'd20;
      line_valid = '0;
      for (int i = 0; i < (1 << 15); i++) begin
         model_mem[i] = '0;
      end
      for (int i = 0; i < mem_geom_pkg::num_lines; i++) begin
         line_tag[i] = '0;
      end

      // Cold read, write-allocate line, dirty victim eviction
      add_row(1'b0, 16'h1234, 16'h0000);
      add_row(1'b1, 16'h2468, 16'hbeef);
      add_row(1'b0, 16'h2468, 16'h0000);
      add_row(1'b0, 16'h246a, 16'h0000);
      add_row(1'b1, 16'h4100, 16'ha5a5);
      add_row(1'b1, 16'h4900, 16'h5a5a);
      add_row(1'b0, 16'h4100, 16'h0000);
      add_row(1'b0, 16'h4900, 16'h0000);

      // Four tags over four indexes
      for (int i = 0; i < num_random; i++) begin
         op = take_bits(1) != 16'd0;
         a.tag = mem_geom_pkg::tag_t'(take_bits(2));
         a.index = 8'h30 + mem_geom_pkg::index_t'(take_bits(2));
         a.woff = mem_geom_pkg::woff_t'(take_bits(2));
         a.byte_sel = 1'b0;
         d = take_bits(16);
         add_row(op, 16'(a), d);
      end
      predict_rows();

      repeat (4) @(negedge clk);
      rst_n = 1'b1;

      repeat (5) begin
         @(negedge clk);
         check_flag("resp.done", resp.done, 1'b0);
         check_flag("resp.stall", resp.stall, 1'b0);
         check_flag("resp.hit", resp.hit, 1'b0);
      end

      for (int i = 0; i < rows.size(); i++) begin
         apply_row(rows[i], i);
      end

      repeat (2) @(negedge clk);
      $display("Everything OK");
      $finish;
   end

endmodule

//--- flist.f
mem_geom_pkg.sv
mem_req_pkg.sv
line_ram.sv
cache_array.sv
bank_mem.sv
cache_ctrl.sv
mem_system.sv
mem_system_tb.sv
